// ==== Makefile ====
# Verilator build and run for the SoC testbench

SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := soc_tb
FILELIST := tb.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only when the output holds the pass message
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== src/soc_bus_decoder.sv ====
// bus decoder
// selects memory, GPIO or UART from two address bits,
// routes vld to the selected peer and returns its rdy,
// remembers the peer at each handshake to steer the response

`timescale 1ns/1ps

module soc_bus_decoder (
  input  logic              clk,
  input  logic              reset,
  // master side
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  // peer handshakes
  output logic              mem_vld,
  output logic              gpio_vld,
  output logic              uart_vld,
  input  logic              mem_rdy,
  input  logic              gpio_rdy,
  input  logic              uart_rdy,
  // peer responses
  input  tcb_pkg::tcb_rsp_t mem_rsp,
  input  tcb_pkg::tcb_rsp_t gpio_rsp,
  input  tcb_pkg::tcb_rsp_t uart_rsp
);

  soc_pkg::peer_t peer;    // decoded from the current request
  soc_pkg::peer_t peer_q;  // peer of the last handshake
  logic           rsp_q;   // response due in this cycle

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // bit 17 splits memory from peripherals, bit 6 splits GPIO from UART
  always_comb begin
    if (!req.adr[soc_pkg::MEM_SEL_BIT]) begin
      peer = soc_pkg::mem;
    end else if (req.adr[soc_pkg::PER_SEL_BIT]) begin
      peer = soc_pkg::uart;
    end else begin
      peer = soc_pkg::gpio;
    end
  end

  assign mem_vld  = vld && (peer == soc_pkg::mem);
  assign gpio_vld = vld && (peer == soc_pkg::gpio);
  assign uart_vld = vld && (peer == soc_pkg::uart);

  // only the selected peer may stall the master
  always_comb begin
    case (peer)
      soc_pkg::gpio: rdy = gpio_rdy;
      soc_pkg::uart: rdy = uart_rdy;
      default:       rdy = mem_rdy;
    endcase
  end

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  // source of the next response is kept apart from the request decode
  // so a new request can be taken in the response cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      peer_q <= soc_pkg::mem;
      rsp_q  <= 1'b0;
    end else begin
      rsp_q <= vld && rdy;
      if (vld && rdy) begin
        peer_q <= peer;
      end
    end
  end

  // idle cycles carry no data and no error
  always_comb begin
    rsp = '0;
    if (rsp_q) begin
      case (peer_q)
        soc_pkg::mem:  rsp = mem_rsp;
        soc_pkg::gpio: rsp = gpio_rsp;
        soc_pkg::uart: rsp = uart_rsp;
        default:       rsp = '0;
      endcase
    end
  end

endmodule

// ==== src/soc_gpio.sv ====
// GPIO controller
// output and output enable registers written over the bus,
// pin inputs sampled through a two stage synchronizer

`timescale 1ns/1ps

module soc_gpio (
  input  logic              clk,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  output soc_pkg::gpio_t    gpio_o,
  output soc_pkg::gpio_t    gpio_e,
  input  soc_pkg::gpio_t    gpio_i
);

  soc_pkg::ofs_t  ofs;
  logic           bad;
  soc_pkg::gpio_t out_q;
  soc_pkg::gpio_t ena_q;
  // synchronizer stages
  soc_pkg::gpio_t inp_m;
  soc_pkg::gpio_t inp_q;
  tcb_pkg::dat_t  rdt_q;
  logic           err_q;

  // never stalls
  assign rdy = 1'b1;
  assign ofs = req.adr[soc_pkg::PER_SEL_BIT:0];

  // input register is read only, other offsets are holes
  always_comb begin
    case (ofs)
      soc_pkg::GPIO_OUT: bad = 1'b0;
      soc_pkg::GPIO_ENA: bad = 1'b0;
      soc_pkg::GPIO_INP: bad = req.wen;
      default:           bad = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_q <= '0;
      ena_q <= '0;
    end else if (vld && req.wen && !bad) begin
      if (ofs == soc_pkg::GPIO_OUT) begin
        out_q <= soc_pkg::gpio_t'(req.wdt);
      end
      if (ofs == soc_pkg::GPIO_ENA) begin
        ena_q <= soc_pkg::gpio_t'(req.wdt);
      end
    end
  end

  // pins are asynchronous
  always_ff @(posedge clk) begin
    inp_m <= gpio_i;
    inp_q <= inp_m;
  end

  assign gpio_o = out_q;
  assign gpio_e = ena_q;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= vld && bad;
    end
  end

  always_ff @(posedge clk) begin
    if (vld) begin
      case (ofs)
        soc_pkg::GPIO_OUT: rdt_q <= tcb_pkg::dat_t'(out_q);
        soc_pkg::GPIO_ENA: rdt_q <= tcb_pkg::dat_t'(ena_q);
        soc_pkg::GPIO_INP: rdt_q <= bad ? '0 : tcb_pkg::dat_t'(inp_q);
        default:           rdt_q <= '0;
      endcase
    end
  end

  assign rsp.rdt = rdt_q;
  assign rsp.err = err_q;

endmodule

// ==== src/soc_memory.sv ====
// data memory
// converts RISC-V size/unsigned/offset accesses into byte lanes,
// extracts and extends read data, flags misaligned accesses

`timescale 1ns/1ps

module soc_memory (
  input  logic              clk,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  tcb_pkg::dat_t   mem_a [0:soc_pkg::MEM_DEP-1];
  soc_pkg::mem_idx_t idx;
  tcb_pkg::ben_t   ben;
  tcb_pkg::dat_t   wdt;
  logic            mal;
  // registered read side
  tcb_pkg::dat_t   rdt_q;
  tcb_pkg::siz_t   siz_q;
  logic [1:0]      ofs_q;
  logic            uns_q;
  logic            err_q;
  tcb_pkg::dat_t   sft;

  assign rdy = 1'b1;
  assign idx = req.adr[soc_pkg::MEM_ADR-1:2];

  ////////////////////////////////////////
  // byte lanes
  ////////////////////////////////////////

  always_comb begin
    case (req.siz)
      tcb_pkg::SIZ_B: begin
        ben = 4'b0001 << req.adr[1:0];
        wdt = {4{req.wdt[7:0]}};
        mal = 1'b0;
      end
      tcb_pkg::SIZ_H: begin
        ben = req.adr[1] ? 4'b1100 : 4'b0011;
        wdt = {2{req.wdt[15:0]}};
        mal = req.adr[0];
      end
      tcb_pkg::SIZ_W: begin
        ben = 4'b1111;
        wdt = req.wdt;
        mal = |req.adr[1:0];
      end
      // 64-bit accesses do not exist here
      default: begin
        ben = 4'b0000;
        wdt = req.wdt;
        mal = 1'b1;
      end
    endcase
  end

  // misaligned writes leave the array untouched
  always_ff @(posedge clk) begin
    if (vld && req.wen && !mal) begin
      for (int i = 0; i < tcb_pkg::BLEN; i++) begin
        if (ben[i]) begin
          mem_a[idx][8*i +: 8] <= wdt[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld && !req.wen) begin
      rdt_q <= mem_a[idx];
    end
    if (vld) begin
      siz_q <= req.siz;
      ofs_q <= req.adr[1:0];
      uns_q <= req.uns;
    end
    err_q <= vld && mal;
  end

  ////////////////////////////////////////
  // read extraction
  ////////////////////////////////////////

  // move the addressed lane down to bit 0
  assign sft = rdt_q >> {ofs_q, 3'b000};

  always_comb begin
    rsp.err = err_q;
    case (siz_q)
      tcb_pkg::SIZ_B: rsp.rdt = {{24{!uns_q && sft[7]}}, sft[7:0]};
      tcb_pkg::SIZ_H: rsp.rdt = {{16{!uns_q && sft[15]}}, sft[15:0]};
      default:        rsp.rdt = sft;
    endcase
    // errors return zero data
    if (err_q) begin
      rsp.rdt = '0;
    end
  end

endmodule

// ==== src/soc_pkg.sv ====
// SoC level definitions
// address map, peripheral register offsets, GPIO width,
// UART divider and the UART transmitter state encoding

package soc_pkg;

  // memory size in address bits for 16KiB
  localparam int unsigned MEM_ADR = 14;
  // memory depth in 32-bit words
  localparam int unsigned MEM_DEP = 2**(MEM_ADR-2);
  typedef logic [MEM_ADR-3:0] mem_idx_t;

  // address bits used by the decoder
  localparam int unsigned MEM_SEL_BIT = 17;  // 0 memory, 1 peripherals
  localparam int unsigned PER_SEL_BIT = 6;   // 0 GPIO, 1 UART

  // register offset inside the peripheral window
  typedef logic [PER_SEL_BIT:0] ofs_t;

  localparam ofs_t GPIO_OUT = 7'h00;
  localparam ofs_t GPIO_ENA = 7'h04;
  localparam ofs_t GPIO_INP = 7'h08;
  localparam ofs_t UART_TXD = 7'h40;
  localparam ofs_t UART_STS = 7'h44;

  // GPIO
  localparam int unsigned GW = 32;
  typedef logic [GW-1:0] gpio_t;

  // UART with a short bit time for simulation
  localparam int unsigned UART_DIV = 8;
  localparam int unsigned UART_CW  = $clog2(UART_DIV);
  typedef logic [UART_CW-1:0] uart_cnt_t;
  typedef logic [7:0]         uart_byte_t;

  typedef enum logic [1:0] {idle, start, data, stop} uart_state_t;

  // bus peers behind the decoder
  typedef enum logic [1:0] {mem, gpio, uart} peer_t;

endpackage

// ==== src/soc_top.sv ====
// SoC top without a core
// external TCB master port feeding the decoder,
// data memory, GPIO controller and UART transmitter

`timescale 1ns/1ps

module soc_top (
  input  logic              clk,
  input  logic              reset,
  // TCB master port
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  // GPIO pins
  output soc_pkg::gpio_t    gpio_o,
  output soc_pkg::gpio_t    gpio_e,
  input  soc_pkg::gpio_t    gpio_i,
  // UART
  output logic              uart_txd
);

  // per peer handshakes with req broadcast to all
  logic              mem_vld;
  logic              gpio_vld;
  logic              uart_vld;
  logic              mem_rdy;
  logic              gpio_rdy;
  logic              uart_rdy;
  tcb_pkg::tcb_rsp_t mem_rsp;
  tcb_pkg::tcb_rsp_t gpio_rsp;
  tcb_pkg::tcb_rsp_t uart_rsp;

  ////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////

  soc_bus_decoder dec_i (
    .clk      (clk),
    .reset    (reset),
    .vld      (vld),
    .req      (req),
    .rdy      (rdy),
    .rsp      (rsp),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .uart_vld (uart_vld),
    .mem_rdy  (mem_rdy),
    .gpio_rdy (gpio_rdy),
    .uart_rdy (uart_rdy),
    .mem_rsp  (mem_rsp),
    .gpio_rsp (gpio_rsp),
    .uart_rsp (uart_rsp)
  );

  ////////////////////////////////////////
  // peers
  ////////////////////////////////////////

  soc_memory mem_i (
    .clk (clk),
    .vld (mem_vld),
    .req (req),
    .rdy (mem_rdy),
    .rsp (mem_rsp)
  );

  soc_gpio gpio_i_inst (
    .clk    (clk),
    .reset  (reset),
    .vld    (gpio_vld),
    .req    (req),
    .rdy    (gpio_rdy),
    .rsp    (gpio_rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  soc_uart_tx uart_i (
    .clk      (clk),
    .reset    (reset),
    .vld      (uart_vld),
    .req      (req),
    .rdy      (uart_rdy),
    .rsp      (uart_rsp),
    .uart_txd (uart_txd)
  );

endmodule

// ==== src/soc_uart_tx.sv ====
// UART transmitter
// 8N1 frames at a fixed divider, data and status registers,
// a data write while a frame is in flight is held off with rdy

`timescale 1ns/1ps

module soc_uart_tx (
  input  logic              clk,
  input  logic              reset,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  output logic              uart_txd
);

  soc_pkg::ofs_t        ofs;
  logic                 bad;
  logic                 wr_txd;
  logic                 busy;
  logic                 load;
  logic                 tick;
  soc_pkg::uart_state_t state;
  soc_pkg::uart_cnt_t   cnt;
  logic [2:0]           bit_cnt;
  soc_pkg::uart_byte_t  sh_q;
  soc_pkg::uart_byte_t  dat_q;
  logic                 txd_q;
  tcb_pkg::dat_t        rdt_q;
  logic                 err_q;

  ////////////////////////////////////////
  // bus side
  ////////////////////////////////////////

  assign ofs    = req.adr[soc_pkg::PER_SEL_BIT:0];
  assign busy   = (state != soc_pkg::idle);
  assign wr_txd = req.wen && (ofs == soc_pkg::UART_TXD);

  // status is read only
  assign bad = (ofs == soc_pkg::UART_STS) ? req.wen : (ofs != soc_pkg::UART_TXD);

  // stall new data until the frame is out
  assign rdy  = !(vld && wr_txd && busy);
  assign load = vld && wr_txd && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= vld && rdy && bad;
    end
  end

  always_ff @(posedge clk) begin
    if (vld && rdy) begin
      case (ofs)
        soc_pkg::UART_TXD: rdt_q <= tcb_pkg::dat_t'(dat_q);
        soc_pkg::UART_STS: rdt_q <= {31'd0, busy};
        default:           rdt_q <= '0;
      endcase
    end
  end

  assign rsp.rdt = rdt_q;
  assign rsp.err = err_q;

  // data register holds the last byte sent
  always_ff @(posedge clk) begin
    if (load) begin
      dat_q <= req.wdt[7:0];
    end
  end

  ////////////////////////////////////////
  // transmit FSM
  ////////////////////////////////////////

  // end of a bit period
  assign tick = (cnt == soc_pkg::uart_cnt_t'(soc_pkg::UART_DIV-1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= soc_pkg::idle;
      cnt     <= '0;
      bit_cnt <= '0;
      txd_q   <= 1'b1;
    end else begin
      cnt <= tick ? '0 : cnt + 1'b1;
      case (state)
        soc_pkg::idle: begin
          // start bit goes out on the next cycle
          if (load) begin
            state <= soc_pkg::start;
            cnt   <= '0;
            txd_q <= 1'b0;
          end
        end
        soc_pkg::start: begin
          if (tick) begin
            state   <= soc_pkg::data;
            bit_cnt <= '0;
            txd_q   <= sh_q[0];
          end
        end
        soc_pkg::data: begin
          if (tick) begin
            if (bit_cnt == 3'd7) begin
              state <= soc_pkg::stop;
              txd_q <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              txd_q   <= sh_q[0];
            end
          end
        end
        default: begin
          // stop bit
          if (tick) begin
            state <= soc_pkg::idle;
          end
        end
      endcase
    end
  end

  // lsb first and shifted as each bit is driven
  always_ff @(posedge clk) begin
    if (load) begin
      sh_q <= req.wdt[7:0];
    end else if (tick && (state == soc_pkg::start || state == soc_pkg::data)) begin
      sh_q <= sh_q >> 1;
    end
  end

  assign uart_txd = txd_q;

endmodule

// ==== src/tcb_pkg.sv ====
// TCB bus definitions
// widths, request and response structs and RISC-V access size codes
// shared by the master port, the decoder and every peer

package tcb_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // byte lanes per data word
  localparam int unsigned BLEN = XLEN/8;

  typedef logic [XLEN-1:0] adr_t;
  typedef logic [XLEN-1:0] dat_t;
  // one enable per byte lane
  typedef logic [BLEN-1:0] ben_t;
  // RISC-V access size, log2 of bytes
  typedef logic [1:0]      siz_t;

  // size codes match funct3[1:0] of loads/stores
  localparam siz_t SIZ_B = 2'd0;
  localparam siz_t SIZ_H = 2'd1;
  localparam siz_t SIZ_W = 2'd2;

  ////////////////////////////////////////
  // request and response
  ////////////////////////////////////////

  typedef struct packed {
    logic wen;  // write enable
    adr_t adr;  // byte address
    siz_t siz;  // access size
    logic uns;  // unsigned load
    dat_t wdt;  // write data, lane 0 aligned
  } tcb_req_t;

  typedef struct packed {
    dat_t rdt;  // read data
    logic err;  // access error
  } tcb_rsp_t;

endpackage

// ==== tb.f ====
src/tcb_pkg.sv
src/soc_pkg.sv
src/soc_bus_decoder.sv
src/soc_memory.sv
src/soc_gpio.sv
src/soc_uart_tx.sv
src/soc_top.sv
verif/soc_chk.sv
verif/soc_tb.sv

// ==== verif/soc_chk.sv ====
// SoC port checker
// reset values on the pins, errors only in response cycles,
// rdy held high while the master is idle

`timescale 1ns/1ps

module soc_chk (
  input logic              clk,
  input logic              reset,
  input logic              vld,
  input logic              rdy,
  input tcb_pkg::tcb_rsp_t rsp,
  input soc_pkg::gpio_t    gpio_e,
  input logic              uart_txd
);

  // pins come out of reset idle
  a_reset_pins: assert property (@(posedge clk) reset |=> (gpio_e == '0) && uart_txd)
    else $error("gpio_e or uart_txd not idle after reset");

  // err only in the cycle after a handshake
  a_err_idle: assert property (@(posedge clk) disable iff (reset)
    !$past(vld && rdy) |-> !rsp.err)
    else $error("rsp.err set outside a response cycle");

  // no stall without a request
  a_rdy_idle: assert property (@(posedge clk) disable iff (reset) !vld |-> rdy)
    else $error("rdy low while vld is low");

endmodule

bind soc_top soc_chk chk_i (
  .clk      (clk),
  .reset    (reset),
  .vld      (vld),
  .rdy      (rdy),
  .rsp      (rsp),
  .gpio_e   (gpio_e),
  .uart_txd (uart_txd)
);

// ==== verif/soc_tb.sv ====
// SoC testbench
// replays bus transactions from a data file on the master port,
// checks responses, GPIO pins and decoded UART frames

`timescale 1ns/1ps

module soc_tb;

  localparam int BUS_TIMEOUT  = 200;
  localparam int UART_TIMEOUT = 400;
  // synchronizer lag plus margin
  localparam int GPIO_SETTLE  = 4;

  logic              clk;
  logic              reset;
  logic              vld;
  tcb_pkg::tcb_req_t req;
  logic              rdy;
  tcb_pkg::tcb_rsp_t rsp;
  soc_pkg::gpio_t    gpio_o;
  soc_pkg::gpio_t    gpio_e;
  soc_pkg::gpio_t    gpio_i;
  logic              uart_txd;

  logic                hs;          // handshake at the last rising edge
  logic                stall_seen;  // rdy low under vld at least once
  soc_pkg::uart_byte_t uart_q [$];  // decoded frames, oldest first
  integer              seed;

  soc_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .vld      (vld),
    .req      (req),
    .rdy      (rdy),
    .rsp      (rsp),
    .gpio_o   (gpio_o),
    .gpio_e   (gpio_e),
    .gpio_i   (gpio_i),
    .uart_txd (uart_txd)
  );

  // 20ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // pre-edge view of the handshake
  always @(posedge clk) begin
    if (reset) begin
      hs         <= 1'b0;
      stall_seen <= 1'b0;
    end else begin
      hs <= vld && rdy;
      if (vld && !rdy) begin
        stall_seen <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // reporting and compares
  ////////////////////////////////////////

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rdt(input string name, input tcb_pkg::dat_t exp,
                           input tcb_pkg::dat_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected err %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_gpio(input string name, input soc_pkg::gpio_t exp,
                            input soc_pkg::gpio_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_byte(input string name, input soc_pkg::uart_byte_t exp,
                            input soc_pkg::uart_byte_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // bus and UART helpers
  ////////////////////////////////////////

  // called on a falling edge and returns on the falling edge of the response cycle
  task automatic bus_access(input logic wen, input tcb_pkg::adr_t adr,
                            input tcb_pkg::siz_t siz, input logic uns,
                            input tcb_pkg::dat_t wdt, output tcb_pkg::tcb_rsp_t r);
    int n;
    n = 0;
    vld     = 1'b1;
    req.wen = wen;
    req.adr = adr;
    req.siz = siz;
    req.uns = uns;
    req.wdt = wdt;
    // hold the request until it is taken
    do begin
      @(negedge clk);
      n++;
    end while (!hs && n < BUS_TIMEOUT);
    if (!hs) begin
      report_failure($sformatf("timeout: no handshake for address %h", adr));
    end
    r   = rsp;
    vld = 1'b0;
  endtask

  // pop the next decoded frame, waiting for its start bit if needed
  task automatic expect_uart(input string name, input soc_pkg::uart_byte_t exp);
    int                  n;
    soc_pkg::uart_byte_t got;
    n = 0;
    while (uart_q.size() == 0 && n < UART_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (uart_q.size() == 0) begin
      report_failure($sformatf("timeout: no UART frame arrived for %s", name));
    end
    got = uart_q.pop_front();
    check_byte(name, exp, got);
  endtask

  // UART frame decoder sampling at bit centers
  initial begin : uart_monitor
    soc_pkg::uart_byte_t b;
    logic                prev;
    prev = 1'b1;
    forever begin
      @(negedge clk);
      if (!reset && prev && uart_txd === 1'b0) begin
        // half a bit into the start bit
        repeat (soc_pkg::UART_DIV/2 - 1) @(negedge clk);
        if (uart_txd !== 1'b0) begin
          report_failure("UART start bit ended early");
        end
        // lsb first
        for (int i = 0; i < 8; i++) begin
          repeat (soc_pkg::UART_DIV) @(negedge clk);
          b[i] = uart_txd;
        end
        repeat (soc_pkg::UART_DIV) @(negedge clk);
        if (uart_txd !== 1'b1) begin
          report_failure("UART stop bit missing");
        end
        uart_q.push_back(b);
      end
      prev = (uart_txd !== 1'b0);
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main
    int                fd;
    int                cnt;
    int                gap;
    int                siz_i;
    int                uns_i;
    int                err_i;
    logic [8*16-1:0]   kind_v;
    logic [8*32-1:0]   name_v;
    logic [8*128-1:0]  rest_v;
    string             kind;
    string             name;
    tcb_pkg::adr_t     adr;
    tcb_pkg::dat_t     wdt;
    tcb_pkg::dat_t     exp_rdt;
    logic              exp_err;
    soc_pkg::ofs_t     ofs;
    tcb_pkg::tcb_rsp_t r;

    seed   = 54;
    reset  = 1'b1;
    vld    = 1'b0;
    req    = '0;
    gpio_i = '0;

    fd = $fopen("verif/soc_tests.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open verif/soc_tests.txt");
    end

    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // idle state after reset
    check_gpio("reset_gpio_o", '0, gpio_o);
    check_gpio("reset_gpio_e", '0, gpio_e);
    check_err("reset_rsp_err", 1'b0, rsp.err);
    if (rdy !== 1'b1 || uart_txd !== 1'b1) begin
      report_failure("rdy or uart_txd not high after reset");
    end

    while (!$feof(fd)) begin
      cnt = $fscanf(fd, "%s", kind_v);
      if (cnt != 1) begin
        break;
      end
      kind = $sformatf("%0s", kind_v);
      // drop the rest of a comment line
      if (kind == "#") begin
        cnt = $fgets(rest_v, fd);
        continue;
      end
      cnt = $fscanf(fd, "%h %d %d %h %h %d %s",
                    adr, siz_i, uns_i, wdt, exp_rdt, err_i, name_v);
      if (cnt != 7) begin
        report_failure("malformed line in verif/soc_tests.txt");
      end
      name    = $sformatf("%0s", name_v);
      exp_err = (err_i != 0);
      ofs     = adr[soc_pkg::PER_SEL_BIT:0];

      if (kind == "wr") begin
        bus_access(1'b1, adr, tcb_pkg::siz_t'(siz_i), uns_i != 0, wdt, r);
        check_err(name, exp_err, r.err);
        // GPIO writes show on the pins right after the handshake
        if (adr[soc_pkg::MEM_SEL_BIT] && !adr[soc_pkg::PER_SEL_BIT] && !exp_err) begin
          if (ofs == soc_pkg::GPIO_OUT) begin
            check_gpio(name, soc_pkg::gpio_t'(wdt), gpio_o);
          end
          if (ofs == soc_pkg::GPIO_ENA) begin
            check_gpio(name, soc_pkg::gpio_t'(wdt), gpio_e);
          end
        end
      end else if (kind == "rd") begin
        bus_access(1'b0, adr, tcb_pkg::siz_t'(siz_i), uns_i != 0, '0, r);
        check_rdt(name, exp_rdt, r.rdt);
        check_err(name, exp_err, r.err);
      end else if (kind == "gpi") begin
        gpio_i = soc_pkg::gpio_t'(wdt);
        repeat (GPIO_SETTLE) @(negedge clk);
      end else if (kind == "uart") begin
        expect_uart(name, soc_pkg::uart_byte_t'(wdt));
      end else begin
        report_failure($sformatf("unknown kind %s in verif/soc_tests.txt", kind));
      end

      // idle gap of 0 to 3 cycles
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
    end
    $fclose(fd);

    // every frame consumed and back-pressure exercised
    if (stall_seen && uart_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else if (!stall_seen) begin
      report_failure("UART data write was never held off by rdy");
    end else begin
      report_failure("UART sent more frames than the test file expects");
    end
  end

endmodule

// ==== verif/soc_tests.txt ====
# kind adr siz uns wdata exp_rdata exp_err name
# kinds wr rd gpi (wdata drives gpio_i) uart (wdata is the expected byte)
wr   00000100 2 0 8badf00d 00000000 0 mem_wr_word
rd   00000100 2 0 00000000 8badf00d 0 mem_rd_word
rd   00000100 1 0 00000000 fffff00d 0 mem_rd_half0_signed
rd   00000102 1 1 00000000 00008bad 0 mem_rd_half1_unsigned
rd   00000103 0 0 00000000 ffffff8b 0 mem_rd_byte3_signed
rd   00000101 0 1 00000000 000000f0 0 mem_rd_byte1_unsigned
wr   00000102 0 0 0000007e 00000000 0 mem_wr_byte2
wr   00000100 1 0 00001234 00000000 0 mem_wr_half0
rd   00000100 2 0 00000000 8b7e1234 0 mem_rd_merged
rd   00000102 0 0 00000000 0000007e 0 mem_rd_byte2_signed
wr   00000101 1 0 0000ffff 00000000 1 mem_wr_half_misaligned
rd   00000102 2 0 00000000 00000000 1 mem_rd_word_misaligned
rd   00000100 2 0 00000000 8b7e1234 0 mem_rd_after_misaligned
wr   00020000 2 0 a5a5c3c3 00000000 0 gpio_wr_out
wr   00020004 2 0 0000ffff 00000000 0 gpio_wr_ena
rd   00020000 2 0 00000000 a5a5c3c3 0 gpio_rd_out
rd   00020004 2 0 00000000 0000ffff 0 gpio_rd_ena
gpi  00000000 0 0 13579bdf 00000000 0 gpio_set_inp
rd   00020008 2 0 00000000 13579bdf 0 gpio_rd_inp
wr   00020008 2 0 ffffffff 00000000 1 gpio_wr_inp_err
rd   0002000c 2 0 00000000 00000000 1 gpio_rd_hole_err
rd   00000100 2 0 00000000 8b7e1234 0 mem_rd_after_gpio_err
wr   00020040 2 0 00000055 00000000 0 uart_wr_first
rd   00020044 2 0 00000000 00000001 0 uart_sts_busy
wr   00020040 2 0 000000c3 00000000 0 uart_wr_stalled
uart 00000000 0 0 00000055 00000000 0 uart_frame_first
uart 00000000 0 0 000000c3 00000000 0 uart_frame_second
rd   00020048 2 0 00000000 00000000 1 uart_rd_hole_err
wr   00020044 2 0 00000001 00000000 1 uart_wr_sts_err
rd   00000100 2 0 00000000 8b7e1234 0 mem_rd_after_uart_err
